/* verilog/mipsPkg.sv */
package mipsPkg;

	localparam int WORD_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int OPCODE_WIDTH = 6;
	localparam int FUNCT_WIDTH = 6;
	localparam int REG_COUNT = 32;

	// Slots between decode and write-back (ex, mem, wb)
	localparam int WB_DEPTH = 3;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [FUNCT_WIDTH-1:0] funct_t;

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_JAL = 6'h03;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_ORI = 6'h0d;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;

	localparam funct_t FUNCT_JR = 6'h08;

	// Return address register for jal
	localparam regAddr_t LINK_REG = 5'd31;

	typedef enum logic [1:0] {
		RD = 2'd0,
		RT = 2'd1,
		LINK = 2'd2
	} writeAddrSource_e;

	typedef enum logic [1:0] {
		ALU = 2'd0,
		MEM = 2'd1,
		PC = 2'd2
	} writeDataSource_e;

	typedef struct packed {
		logic writeEnable;
		writeAddrSource_e writeAddrSource;
		writeDataSource_e writeDataSource;
	} regControl_t;

	// What the register stage hands down the pipe and gets back at write-back
	typedef struct packed {
		regAddr_t read1Addr;
		regAddr_t read2Addr;
		regAddr_t writeAddr;
		writeDataSource_e writeData;
		logic writeEn;
	} regPorts_t;

endpackage

/* verilog/regControl.sv */
module regControl
	( input mipsPkg::opcode_t opcode
	, input mipsPkg::funct_t funct
	, output mipsPkg::regControl_t regCtrl
	);

	always_comb begin
		// Nothing written unless the opcode says so
		regCtrl.writeEnable = 1'b0;
		regCtrl.writeAddrSource = mipsPkg::RD;
		regCtrl.writeDataSource = mipsPkg::ALU;

		case (opcode)
			mipsPkg::OP_RTYPE: begin
				// jr only reads rs
				if (funct != mipsPkg::FUNCT_JR) begin
					regCtrl.writeEnable = 1'b1;
				end
			end
			mipsPkg::OP_ADDI,
			mipsPkg::OP_ORI: begin
				regCtrl.writeEnable = 1'b1;
				regCtrl.writeAddrSource = mipsPkg::RT;
			end
			mipsPkg::OP_LW: begin
				regCtrl.writeEnable = 1'b1;
				regCtrl.writeAddrSource = mipsPkg::RT;
				regCtrl.writeDataSource = mipsPkg::MEM;
			end
			mipsPkg::OP_JAL: begin
				regCtrl.writeEnable = 1'b1;
				regCtrl.writeAddrSource = mipsPkg::LINK;
				regCtrl.writeDataSource = mipsPkg::PC;
			end
			default: begin
				regCtrl.writeEnable = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/registerFile.sv */
module registerFile #
	( parameter bit PASSTHROUGH = 1'b0
	)
	( input logic clk
	, input logic arstN
	, input mipsPkg::regAddr_t rd1Addr
	, input mipsPkg::regAddr_t rd2Addr
	, input mipsPkg::regAddr_t wrAddr
	, input logic wrEnable
	, input mipsPkg::word_t wrData
	, output mipsPkg::word_t rd1Data
	, output mipsPkg::word_t rd2Data
	);

	mipsPkg::word_t regs [mipsPkg::REG_COUNT];
	logic doWrite;

	// Register zero is never stored
	assign doWrite = wrEnable && (wrAddr != '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (doWrite) begin
			regs[wrAddr] <= wrData;
		end
	end

	function automatic mipsPkg::word_t readPort(input mipsPkg::regAddr_t addr);
		mipsPkg::word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (PASSTHROUGH && doWrite && (addr == wrAddr)) begin
			// Same-cycle bypass of the write-back value
			value = wrData;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	assign rd1Data = readPort(rd1Addr);
	assign rd2Data = readPort(rd2Addr);

	// Written value lands in the addressed entry by the next edge
	property writeLands;
		@(posedge clk) disable iff (!arstN)
			doWrite |=> (regs[$past(wrAddr)] == $past(wrData));
	endproperty

	assert property (writeLands)
	else $error("registerFile: write did not land");

endmodule

/* verilog/regDatapath.sv */
module regDatapath
	( input mipsPkg::word_t instruction
	, input mipsPkg::regControl_t regCtrl
	, input mipsPkg::regPorts_t portsIn
	, input mipsPkg::word_t wbPcAddr
	, input mipsPkg::word_t memOut
	, input mipsPkg::word_t aluResult
	, input mipsPkg::word_t rd1Data
	, input mipsPkg::word_t rd2Data
	, output mipsPkg::regPorts_t portsOut
	, output mipsPkg::regAddr_t rd1Addr
	, output mipsPkg::regAddr_t rd2Addr
	, output mipsPkg::regAddr_t wrAddr
	, output logic wrEnable
	, output mipsPkg::word_t writeData
	, output mipsPkg::word_t port1
	, output mipsPkg::word_t port2
	, output logic portEq
	);

	mipsPkg::regAddr_t rsField;
	mipsPkg::regAddr_t rtField;
	mipsPkg::regAddr_t rdField;
	mipsPkg::regAddr_t destAddr;

	// Register fields of the decoding instruction
	assign rsField = instruction[25:21];
	assign rtField = instruction[20:16];
	assign rdField = instruction[15:11];

	assign rd1Addr = rsField;
	assign rd2Addr = rtField;

	always_comb begin
		case (regCtrl.writeAddrSource)
			mipsPkg::RT: destAddr = rtField;
			mipsPkg::LINK: destAddr = mipsPkg::LINK_REG;
			default: destAddr = rdField;
		endcase
	end

	always_comb begin
		portsOut.read1Addr = rsField;
		portsOut.read2Addr = rtField;
		portsOut.writeAddr = destAddr;
		portsOut.writeData = regCtrl.writeDataSource;
		portsOut.writeEn = regCtrl.writeEnable;
	end

	// Write-back side, driven by the instruction in the last slot
	assign wrAddr = portsIn.writeAddr;
	assign wrEnable = portsIn.writeEn;

	always_comb begin
		case (portsIn.writeData)
			mipsPkg::MEM: writeData = memOut;
			mipsPkg::PC: writeData = wbPcAddr;
			default: writeData = aluResult;
		endcase
	end

	assign port1 = rd1Data;
	assign port2 = rd2Data;

	// Branch equality for beq
	assign portEq = (rd1Data == rd2Data);

endmodule

/* verilog/writebackPipe.sv */
module writebackPipe
	( input logic clk
	, input logic arstN
	, input mipsPkg::regPorts_t portsOut
	, output mipsPkg::regPorts_t portsIn
	);

	localparam int FILL_WIDTH = $clog2(mipsPkg::WB_DEPTH + 1);

	mipsPkg::regPorts_t slots [mipsPkg::WB_DEPTH];
	logic [FILL_WIDTH-1:0] fillCount;

	// slots[0] is execute, the last one is write-back
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::WB_DEPTH; i++) begin
				slots[i] <= '0;
			end
		end else begin
			slots[0] <= portsOut;
			for (int i = 1; i < mipsPkg::WB_DEPTH; i++) begin
				slots[i] <= slots[i-1];
			end
		end
	end

	assign portsIn = slots[mipsPkg::WB_DEPTH-1];

	// Counts edges since reset until the pipe holds only real instructions
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fillCount <= '0;
		end else if (fillCount != FILL_WIDTH'(mipsPkg::WB_DEPTH)) begin
			fillCount <= fillCount + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN)
		(fillCount == FILL_WIDTH'(mipsPkg::WB_DEPTH))
			|-> (portsIn.writeEn == $past(portsOut.writeEn, mipsPkg::WB_DEPTH)))
	else $error("writebackPipe: write enable lost in the pipe");

endmodule

/* verilog/regStage.sv */
module regStage #
	( parameter bit PASSTHROUGH = 1'b0
	)
	( input logic clk
	, input logic arstN
	, input mipsPkg::word_t instruction
	, input mipsPkg::word_t wbPcAddr
	, input mipsPkg::word_t memOut
	, input mipsPkg::word_t aluResult
	, output mipsPkg::word_t port1
	, output mipsPkg::word_t port2
	, output logic portEq
	, output mipsPkg::word_t writeData
	, output logic wbWriteEn
	, output mipsPkg::regAddr_t wbWriteAddr
	);

	mipsPkg::regControl_t regCtrl;
	mipsPkg::regPorts_t portsOut;
	mipsPkg::regPorts_t portsIn;
	mipsPkg::regAddr_t rd1Addr;
	mipsPkg::regAddr_t rd2Addr;
	mipsPkg::word_t rd1Data;
	mipsPkg::word_t rd2Data;

	regControl i_control
		( .opcode (instruction[31:26])
		, .funct (instruction[5:0])
		, .regCtrl (regCtrl)
		);

	regDatapath i_datapath
		( .instruction (instruction)
		, .regCtrl (regCtrl)
		, .portsIn (portsIn)
		, .wbPcAddr (wbPcAddr)
		, .memOut (memOut)
		, .aluResult (aluResult)
		, .rd1Data (rd1Data)
		, .rd2Data (rd2Data)
		, .portsOut (portsOut)
		, .rd1Addr (rd1Addr)
		, .rd2Addr (rd2Addr)
		, .wrAddr (wbWriteAddr)
		, .wrEnable (wbWriteEn)
		, .writeData (writeData)
		, .port1 (port1)
		, .port2 (port2)
		, .portEq (portEq)
		);

	registerFile #
		( .PASSTHROUGH (PASSTHROUGH)
		) i_regFile
		( .clk (clk)
		, .arstN (arstN)
		, .rd1Addr (rd1Addr)
		, .rd2Addr (rd2Addr)
		, .wrAddr (wbWriteAddr)
		, .wrEnable (wbWriteEn)
		, .wrData (writeData)
		, .rd1Data (rd1Data)
		, .rd2Data (rd2Data)
		);

	writebackPipe i_wbPipe
		( .clk (clk)
		, .arstN (arstN)
		, .portsOut (portsOut)
		, .portsIn (portsIn)
		);

endmodule

/* verif/regStageTb.sv */
module regStageTb;

	localparam int PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_CYCLES = 2000;

	// Expected write-back of one decoded instruction
	typedef struct packed {
		logic en;
		mipsPkg::regAddr_t addr;
		mipsPkg::writeDataSource_e src;
	} expWrite_t;

	logic clk;
	logic arstN;
	mipsPkg::word_t instruction;
	mipsPkg::word_t wbPcAddr;
	mipsPkg::word_t memOut;
	mipsPkg::word_t aluResult;
	mipsPkg::word_t port1;
	mipsPkg::word_t port2;
	logic portEq;
	mipsPkg::word_t writeData;
	logic wbWriteEn;
	mipsPkg::regAddr_t wbWriteAddr;

	integer seed;
	mipsPkg::word_t modelRegs [32];
	expWrite_t pipeQ [$];

	regStage #
		( .PASSTHROUGH (1'b1)
		) i_dut
		( .clk (clk)
		, .arstN (arstN)
		, .instruction (instruction)
		, .wbPcAddr (wbPcAddr)
		, .memOut (memOut)
		, .aluResult (aluResult)
		, .port1 (port1)
		, .port2 (port2)
		, .portEq (portEq)
		, .writeData (writeData)
		, .wbWriteEn (wbWriteEn)
		, .wbWriteAddr (wbWriteAddr)
		);

	always #(PERIOD / 2) clk = ~clk;

	function automatic expWrite_t decodeWrite(input mipsPkg::word_t instr);
		expWrite_t result;
		result.en = 1'b0;
		result.addr = instr[15:11];
		result.src = mipsPkg::ALU;
		case (instr[31:26])
			mipsPkg::OP_RTYPE: result.en = (instr[5:0] != mipsPkg::FUNCT_JR);
			mipsPkg::OP_ADDI,
			mipsPkg::OP_ORI: begin
				result.en = 1'b1;
				result.addr = instr[20:16];
			end
			mipsPkg::OP_LW: begin
				result.en = 1'b1;
				result.addr = instr[20:16];
				result.src = mipsPkg::MEM;
			end
			mipsPkg::OP_JAL: begin
				result.en = 1'b1;
				result.addr = 5'd31;
				result.src = mipsPkg::PC;
			end
			default: result.en = 1'b0;
		endcase
		return result;
	endfunction

	function automatic mipsPkg::word_t selectData(input mipsPkg::writeDataSource_e src);
		case (src)
			mipsPkg::MEM: return memOut;
			mipsPkg::PC: return wbPcAddr;
			default: return aluResult;
		endcase
	endfunction

	function automatic mipsPkg::word_t expectedRead(input mipsPkg::regAddr_t addr,
		input expWrite_t wb, input mipsPkg::word_t wbData);
		if (addr == 5'd0) begin
			return '0;
		end else if (wb.en && (wb.addr == addr)) begin
			return wbData;
		end
		return modelRegs[addr];
	endfunction

	// Mostly a small set of registers so reads hit recent writes
	function automatic mipsPkg::regAddr_t pickReg();
		int unsigned r;
		r = $unsigned($random(seed)) % 10;
		if (r < 8) begin
			return mipsPkg::regAddr_t'(r);
		end else if (r == 8) begin
			return 5'd31;
		end
		return mipsPkg::regAddr_t'($random(seed));
	endfunction

	task automatic driveInputs();
		int unsigned kind;
		mipsPkg::word_t instr;
		kind = $unsigned($random(seed)) % 16;
		instr = $random(seed);
		instr[25:21] = pickReg();
		instr[20:16] = pickReg();
		instr[15:11] = pickReg();
		if (kind < 4) begin
			instr[31:26] = mipsPkg::OP_RTYPE;
			if (instr[5:0] == mipsPkg::FUNCT_JR) begin
				instr[5:0] = 6'h21;
			end
		end else if (kind < 5) begin
			instr[31:26] = mipsPkg::OP_RTYPE;
			instr[5:0] = mipsPkg::FUNCT_JR;
		end else if (kind < 7) begin
			instr[31:26] = mipsPkg::OP_ADDI;
		end else if (kind < 9) begin
			instr[31:26] = mipsPkg::OP_ORI;
		end else if (kind < 11) begin
			instr[31:26] = mipsPkg::OP_LW;
		end else if (kind < 13) begin
			instr[31:26] = mipsPkg::OP_SW;
		end else if (kind < 14) begin
			instr[31:26] = mipsPkg::OP_BEQ;
		end else begin
			instr[31:26] = mipsPkg::OP_JAL;
		end
		instruction = instr;
		wbPcAddr = $random(seed);
		memOut = $random(seed);
		aluResult = $random(seed);
	endtask

	task automatic checkValue(input string name, input mipsPkg::word_t expected,
		input mipsPkg::word_t actual);
		assert (actual === expected)
		else begin
			$display("ERROR at %0t: %s expected 0x%08h, actual 0x%08h",
				$time, name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Output mismatch");
		end
	endtask

	// Checks one time unit before the rising edge, then advances the model
	always begin : compareProc
		expWrite_t wb;
		mipsPkg::word_t wbData;
		mipsPkg::word_t exp1;
		mipsPkg::word_t exp2;
		@(negedge clk);
		#1;
		if (arstN) begin
			wb = pipeQ[0];
			wbData = selectData(wb.src);
			exp1 = expectedRead(instruction[25:21], wb, wbData);
			exp2 = expectedRead(instruction[20:16], wb, wbData);
			checkValue("port1", exp1, port1);
			checkValue("port2", exp2, port2);
			checkValue("portEq", 32'(exp1 == exp2), 32'(portEq));
			checkValue("wbWriteEn", 32'(wb.en), 32'(wbWriteEn));
			checkValue("writeData", wbData, writeData);
			if (wb.en) begin
				checkValue("wbWriteAddr", 32'(wb.addr), 32'(wbWriteAddr));
				if (wb.addr != 5'd0) begin
					modelRegs[wb.addr] = wbData;
				end
			end
			void'(pipeQ.pop_front());
			pipeQ.push_back(decodeWrite(instruction));
		end
	end

	initial begin
		#((NUM_CYCLES + RESET_CYCLES + 8) * PERIOD);
		$display("Timeout: the test did not finish in the expected time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		seed = 32'h2b38;
		clk = 1'b0;
		arstN = 1'b0;
		instruction = '0;
		wbPcAddr = '0;
		memOut = '0;
		aluResult = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		// Pipe slots come out of reset with no write
		for (int i = 0; i < mipsPkg::WB_DEPTH; i++) begin
			pipeQ.push_back('0);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		for (int i = 0; i < NUM_CYCLES; i++) begin
			driveInputs();
			@(negedge clk);
		end
		#(PERIOD / 2);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* filelist.f */
verilog/mipsPkg.sv
verilog/regControl.sv
verilog/registerFile.sv
verilog/regDatapath.sv
verilog/writebackPipe.sv
verilog/regStage.sv
verif/regStageTb.sv

/* Makefile */
TOP = regStageTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
